// ==== Bender.yml ====
package:
  name: eth_tx

sources:
  - common/eth_frame_pkg.sv
  - common/eth_phy_pkg.sv
  - verilog/eth_crc32.sv
  - verilog/eth_bit_order.sv
  - eth_tx/eth_header_gen.sv
  - eth_tx/eth_tx_framer.sv
  - verilog/eth_tx.sv
  - target: test
    files:
      - verif/eth_tx_tb.sv

// ==== common/eth_frame_pkg.sv ====
package eth_frame_pkg;

  // Preamble and start-of-frame delimiter
  localparam logic [7:0] preamble_byte = 8'h55;
  localparam logic [7:0] sfd_byte      = 8'hD5;
  localparam int         preamble_len  = 7;     // Preamble bytes ahead of the SFD

  // Header field widths
  localparam int mac_w   = 48;
  localparam int etype_w = 16;

  // First preamble byte through the EtherType low byte
  localparam int header_len = 22;

  // Frame check sequence, IEEE 802.3 CRC-32 in reflected form
  localparam logic [31:0] crc_poly_refl = 32'hEDB8_8320;
  localparam logic [31:0] crc_init      = 32'hFFFF_FFFF;
  localparam int          crc_len       = 4;    // FCS bytes, low byte first

  // Idle time after each frame
  localparam int ifg_bytes = 12;

endpackage

// ==== common/eth_phy_pkg.sv ====
package eth_phy_pkg;

  // Data lines per clock on the PHY side, two for RMII
  localparam int sym_w = 2;

  // Symbols that make up one byte on the wire
  localparam int sym_per_byte = 8 / sym_w;

endpackage

// ==== eth_tx/eth_header_gen.sv ====
`timescale 1ns/10ps

module eth_header_gen (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              hdr_start,   // Latch config and rewind
  input  logic                              hdr_next,    // Step to the following byte
  input  logic [eth_frame_pkg::mac_w-1:0]   my_mac,
  input  logic [eth_frame_pkg::mac_w-1:0]   dest_mac,
  input  logic [eth_frame_pkg::etype_w-1:0] etype,
  output logic [7:0]                        hdr_byte,
  output logic                              hdr_last,
  output logic                              hdr_in_crc
);

  // Address and type fields in wire order, first byte in the top bits
  logic [2*eth_frame_pkg::mac_w+eth_frame_pkg::etype_w-1:0] shadow;
  logic [4:0] idx;       // 0 is the first preamble byte
  logic [4:0] fld_idx;   // Byte offset into the shadow fields

  always_ff @(posedge clk) begin
    if (hdr_start) begin
      shadow <= {dest_mac, my_mac, etype};
    end
  end

  // Index holds on the last byte until the next frame rewinds it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      idx <= '0;
    end else if (hdr_start) begin
      idx <= '0;
    end else if (hdr_next && !hdr_last) begin
      idx <= idx + 5'd1;
    end
  end

  assign fld_idx = idx - 5'(eth_frame_pkg::preamble_len + 1);

  always_comb begin
    if (idx < 5'(eth_frame_pkg::preamble_len)) begin
      hdr_byte = eth_frame_pkg::preamble_byte;
    end else if (idx == 5'(eth_frame_pkg::preamble_len)) begin
      hdr_byte = eth_frame_pkg::sfd_byte;
    end else begin
      hdr_byte = shadow[$bits(shadow)-1 - 8*fld_idx -: 8];   // MSB first per field
    end
  end

  assign hdr_last   = (idx == 5'(eth_frame_pkg::header_len - 1));   // EtherType low byte
  assign hdr_in_crc = (idx > 5'(eth_frame_pkg::preamble_len));      // Destination MAC onward

  // Once the EtherType low byte has gone, the framer must start a new frame first
  a_no_next_after_last : assert property (
    @(posedge clk) disable iff (!arst_n)
    (hdr_next && hdr_last) |=> (!hdr_next until hdr_start)
  ) else $error("eth_header_gen: hdr_next after the last header byte");

endmodule

// ==== eth_tx/eth_tx_framer.sv ====
`timescale 1ns/10ps

module eth_tx_framer (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [7:0]                    pl_data,
  input  logic                          pl_valid,
  input  logic                          pl_last,
  output logic                          pl_ready,
  output logic                          hdr_start,
  output logic                          hdr_next,
  input  logic [7:0]                    hdr_byte,
  input  logic                          hdr_last,
  input  logic                          hdr_in_crc,
  output logic                          crc_clear,
  output logic                          crc_en,
  output logic [7:0]                    crc_byte,
  input  logic [31:0]                   crc_value,
  output logic                          raw_valid,
  output logic [eth_phy_pkg::sym_w-1:0] raw_sym
);

  typedef enum logic [2:0] {
    st_idle,
    st_header,
    st_payload,
    st_fcs,
    st_gap
  } state_t;

  state_t                                       state;
  logic [$clog2(eth_phy_pkg::sym_per_byte)-1:0] sym_cnt;
  logic [7:0]                                   sreg;      // Byte on its way out, MSB first
  logic [23:0]                                  fcs_sr;    // FCS bytes still queued
  logic [2:0]                                   fcs_cnt;   // FCS bytes loaded so far
  logic [5:0]                                   gap_cnt;
  logic                                         load;
  logic                                         fcs_first;
  logic                                         frame_done;
  logic [31:0]                                  fcs_word;
  logic [7:0]                                   next_byte;

  // Byte slot opens on the first header cycle and after each last symbol
  assign load = raw_valid ? (int'(sym_cnt) == eth_phy_pkg::sym_per_byte - 1)
                          : (state == st_header);

  // Underrun skips the rest of the payload and sends FCS byte 0 at once
  assign fcs_first  = (state == st_payload && !pl_valid) || (state == st_fcs && fcs_cnt == '0);
  assign frame_done = load && state == st_fcs && fcs_cnt == 3'(eth_frame_pkg::crc_len);
  assign fcs_word   = crc_value ^ {32{state == st_payload}};   // Inverted on underrun

  assign hdr_start = (state == st_idle) && pl_valid && (gap_cnt == '0);
  assign hdr_next  = load && (state == st_header);
  assign pl_ready  = load && (state == st_payload);
  assign crc_clear = hdr_start;
  assign crc_en    = load && ((state == st_header && hdr_in_crc) ||
                              (state == st_payload && pl_valid));
  assign crc_byte  = (state == st_header) ? hdr_byte : pl_data;

  always_comb begin
    if (fcs_first) begin
      next_byte = fcs_word[7:0];
    end else if (state == st_fcs) begin
      next_byte = fcs_sr[7:0];
    end else if (state == st_payload) begin
      next_byte = pl_data;
    end else begin
      next_byte = hdr_byte;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_idle;
      fcs_cnt <= '0;
      gap_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (hdr_start) begin
            state <= st_header;
          end
        end
        st_header: begin
          if (load && hdr_last) begin
            state <= st_payload;
          end
        end
        st_payload: begin
          if (load && (!pl_valid || pl_last)) begin
            state   <= st_fcs;
            fcs_cnt <= pl_valid ? 3'd0 : 3'd1;
          end
        end
        st_fcs: begin
          if (frame_done) begin
            state <= st_gap;
            // Three more idle cycles follow through idle and the first header cycle
            gap_cnt <= 6'(eth_frame_pkg::ifg_bytes * eth_phy_pkg::sym_per_byte - 3);
          end else if (load) begin
            fcs_cnt <= fcs_cnt + 3'd1;
          end
        end
        st_gap: begin
          if (gap_cnt == '0) begin
            state <= st_idle;
          end else begin
            gap_cnt <= gap_cnt - 6'd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      raw_valid <= 1'b0;
      sym_cnt   <= '0;
    end else if (load) begin
      raw_valid <= !frame_done;
      sym_cnt   <= '0;
    end else if (raw_valid) begin
      sym_cnt <= sym_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      sreg <= next_byte;
    end else begin
      sreg <= sreg << eth_phy_pkg::sym_w;
    end
    if (load && fcs_first) begin
      fcs_sr <= fcs_word[31:8];
    end else if (load && state == st_fcs) begin
      fcs_sr <= fcs_sr >> 8;
    end
  end

  assign raw_sym = sreg[7 -: eth_phy_pkg::sym_w];

  a_quiet_in_gap : assert property (
    @(posedge clk) disable iff (!arst_n)
    (state == st_gap) |-> !raw_valid
  ) else $error("eth_tx_framer: symbols sent during the inter-frame gap");

endmodule

// ==== list.f ====
common/eth_frame_pkg.sv
common/eth_phy_pkg.sv
verilog/eth_crc32.sv
verilog/eth_bit_order.sv
eth_tx/eth_header_gen.sv
eth_tx/eth_tx_framer.sv
verilog/eth_tx.sv
verif/eth_tx_tb.sv

// ==== verif/eth_tx_tb.sv ====
`timescale 1ns/10ps

module eth_tx_tb;

  localparam int wait_limit = 1000;   // Cycles allowed for any single wait

  logic                              clk;
  logic                              arst_n;
  logic [eth_frame_pkg::mac_w-1:0]   my_mac;
  logic [eth_frame_pkg::mac_w-1:0]   dest_mac;
  logic [eth_frame_pkg::etype_w-1:0] etype;
  logic [7:0]                        pl_data;
  logic                              pl_valid;
  logic                              pl_last;
  logic                              pl_ready;
  logic [eth_phy_pkg::sym_w-1:0]     txd;
  logic                              tx_en;

  int          seed = 32'h1589;
  int          cyc = 0;
  logic [7:0]  payload[$];

  // Expected frames with the bytes before the FCS kept flat
  logic [7:0]  exp_bytes[$];
  int          exp_lens[$];
  logic [31:0] exp_fcs[$];

  // Line monitor state
  logic [7:0]  rx_shift;
  logic [7:0]  rx_bytes[$];
  int          rx_lens[$];
  int          rx_sym = 0;
  int          rx_cnt = 0;
  logic        tx_en_q = 1'b0;
  int          rise_cyc = 0;
  int          fall_cyc = 0;
  int          last_gap = 0;

  eth_tx dut0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .my_mac   (my_mac),
    .dest_mac (dest_mac),
    .etype    (etype),
    .pl_data  (pl_data),
    .pl_valid (pl_valid),
    .pl_last  (pl_last),
    .pl_ready (pl_ready),
    .txd      (txd),
    .tx_en    (tx_en)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // Each symbol carries its first wire bit on txd[1]
  always @(negedge clk) begin
    if (tx_en) begin
      if (!tx_en_q) begin
        rise_cyc = cyc;
        last_gap = cyc - fall_cyc;
        rx_cnt   = 0;
        rx_sym   = 0;
      end
      rx_shift = {txd[0], txd[1], rx_shift[7:2]};
      rx_sym++;
      if (rx_sym == eth_phy_pkg::sym_per_byte) begin
        rx_bytes.push_back(rx_shift);
        rx_cnt++;
        rx_sym = 0;
      end
    end else if (tx_en_q) begin
      fall_cyc = cyc;
      rx_lens.push_back(rx_cnt);
    end
    tx_en_q = tx_en;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_sym(input logic [eth_phy_pkg::sym_w-1:0] got,
                           input logic [eth_phy_pkg::sym_w-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: txd is %b, expected %b", $time, got, exp));
    end
  endtask

  task automatic check_byte(input int idx, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: frame byte %0d is %02h, expected %02h",
                          $time, idx, got, exp));
    end
  endtask

  task automatic check_fcs(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: FCS is %08h, expected %08h", $time, got, exp));
    end
  endtask

  task automatic check_len(input string what, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic gen_payload(input int n);
    logic [31:0] r;
    payload = {};
    repeat (n) begin
      r = $random(seed);
      payload.push_back(r[7:0]);
    end
  endtask

  // Expected frame from the current config and the first n_used payload bytes
  task automatic model_frame(input int n_used, input bit underrun);
    logic [7:0]  f[$];
    logic [31:0] crc;
    logic        fb;
    for (int i = 0; i < eth_frame_pkg::preamble_len; i++) begin
      f.push_back(eth_frame_pkg::preamble_byte);
    end
    f.push_back(eth_frame_pkg::sfd_byte);
    for (int i = 5; i >= 0; i--) begin
      f.push_back(dest_mac[8*i +: 8]);
    end
    for (int i = 5; i >= 0; i--) begin
      f.push_back(my_mac[8*i +: 8]);
    end
    f.push_back(etype[15:8]);
    f.push_back(etype[7:0]);
    for (int i = 0; i < n_used; i++) begin
      f.push_back(payload[i]);
    end
    crc = eth_frame_pkg::crc_init;
    for (int i = eth_frame_pkg::preamble_len + 1; i < f.size(); i++) begin
      for (int b = 0; b < 8; b++) begin
        fb  = crc[0] ^ f[i][b];   // Bit by bit with the LSB of each byte first
        crc = crc >> 1;
        if (fb) begin
          crc = crc ^ eth_frame_pkg::crc_poly_refl;
        end
      end
    end
    exp_fcs.push_back(underrun ? crc : ~crc);
    exp_lens.push_back(f.size());
    foreach (f[i]) begin
      exp_bytes.push_back(f[i]);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge clk);
    while (pl_ready !== 1'b1) begin
      n++;
      if (n > wait_limit) begin
        abort_run("Timeout: pl_ready never opened a slot for the next payload byte");
      end
      @(negedge clk);
    end
  endtask

  // Returns on the first falling clock edge that sees tx_en high
  task automatic wait_line_active();
    int n;
    n = 0;
    @(negedge clk);
    while (tx_en !== 1'b1) begin
      n++;
      if (n > wait_limit) begin
        abort_run("Timeout: tx_en never rose for the frame on offer");
      end
      @(negedge clk);
    end
  endtask

  // Offers the payload; a slot index of -1 means no underrun
  task automatic send_payload(input int underrun_at);
    int n;
    n = (underrun_at < 0) ? payload.size() : underrun_at;
    for (int i = 0; i < n; i++) begin
      pl_valid = 1'b1;
      pl_data  = payload[i];
      pl_last  = (underrun_at < 0) && (i == n - 1);
      wait_ready();
      @(posedge clk);   // Byte taken on this edge
      #1;
    end
    pl_valid = 1'b0;
    pl_last  = 1'b0;
    pl_data  = '0;
    if (underrun_at >= 0) begin
      wait_ready();     // Slot passes with nothing offered
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_frame();
    int          n;
    int          len;
    int          exp_len;
    logic [31:0] fcs;
    n = 0;
    while (rx_lens.size() == 0) begin
      n++;
      if (n > wait_limit) begin
        abort_run("Timeout: no complete frame appeared on tx_en");
      end
      @(negedge clk);
    end
    len     = rx_lens.pop_front();
    exp_len = exp_lens.pop_front();
    check_len("frame length in bytes", len, exp_len + eth_frame_pkg::crc_len);
    for (int i = 0; i < exp_len; i++) begin
      check_byte(i, rx_bytes.pop_front(), exp_bytes.pop_front());
    end
    fcs = '0;
    for (int i = 0; i < eth_frame_pkg::crc_len; i++) begin
      fcs[8*i +: 8] = rx_bytes.pop_front();   // Low byte first
    end
    check_fcs(fcs, exp_fcs.pop_front());
    @(posedge clk);
    #1;
  endtask

  task automatic test_reset_state();
    repeat (6) begin
      @(negedge clk);
      check_bit("tx_en", tx_en, 1'b0);
      check_bit("pl_ready", pl_ready, 1'b0);
      check_sym(txd, '0);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic test_single_byte();
    int start_cyc;
    payload = {8'hA5};
    model_frame(1, 1'b0);
    start_cyc = cyc;
    send_payload(-1);
    check_frame();
    check_len("tx_en delay in cycles", rise_cyc - start_cyc, 6);
  endtask

  task automatic test_random_frames();
    logic [31:0] r;
    repeat (5) begin
      r = $random(seed);
      gen_payload(1 + r[5:0]);
      model_frame(payload.size(), 1'b0);
      send_payload(-1);
      check_frame();
    end
  endtask

  task automatic test_back_to_back();
    gen_payload(10);
    model_frame(10, 1'b0);
    send_payload(-1);
    gen_payload(5);     // Offered right after the last byte of the first frame
    model_frame(5, 1'b0);
    send_payload(-1);
    check_frame();
    check_frame();
    if (last_gap < eth_frame_pkg::ifg_bytes * eth_phy_pkg::sym_per_byte) begin
      abort_run($sformatf("[ERROR] %0t: only %0d idle cycles between frames",
                          $time, last_gap));
    end
  endtask

  task automatic test_config_change();
    gen_payload(8);
    model_frame(8, 1'b0);
    fork
      send_payload(-1);
      begin
        wait_line_active();   // Preamble on the wire, addresses not yet sent
        @(posedge clk);
        #1;
        dest_mac = 48'h0A_0B_0C_0D_0E_0F;
        etype    = 16'h86DD;
      end
    join
    gen_payload(6);
    model_frame(6, 1'b0);
    send_payload(-1);
    check_frame();
    check_frame();
  endtask

  task automatic test_underrun();
    gen_payload(12);
    model_frame(5, 1'b1);
    send_payload(5);
    check_frame();
  endtask

  initial begin
    arst_n   = 1'b0;
    my_mac   = 48'h02_11_22_33_44_55;
    dest_mac = 48'hFF_FF_FF_FF_FF_FF;
    etype    = 16'h0800;
    pl_data  = '0;
    pl_valid = 1'b0;
    pl_last  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    test_reset_state();
    test_single_byte();
    test_random_frames();
    test_back_to_back();
    test_config_change();
    test_underrun();

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== verilog/eth_bit_order.sv ====
`timescale 1ns/10ps

module eth_bit_order (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          raw_valid,
  input  logic [eth_phy_pkg::sym_w-1:0] raw_sym,   // MSB-first symbols
  output logic                          tx_en,
  output logic [eth_phy_pkg::sym_w-1:0] txd
);

  localparam int cnt_w = $clog2(eth_phy_pkg::sym_per_byte);

  logic [7:0]       byte_buf [2];   // Ping-pong, one fills while the other drains
  logic             wr_sel;
  logic             rd_sel;
  logic [cnt_w-1:0] wr_cnt;         // Symbol slot being written
  logic [cnt_w-1:0] rd_sym;         // Next stored symbol to play
  logic             play;

  function automatic logic [eth_phy_pkg::sym_w-1:0] flip(
    input logic [eth_phy_pkg::sym_w-1:0] s
  );
    logic [eth_phy_pkg::sym_w-1:0] r;
    for (int i = 0; i < eth_phy_pkg::sym_w; i++) begin
      r[i] = s[eth_phy_pkg::sym_w-1-i];
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (raw_valid) begin
      byte_buf[wr_sel][7 - eth_phy_pkg::sym_w*wr_cnt -: eth_phy_pkg::sym_w] <= raw_sym;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_sel <= 1'b0;
      wr_cnt <= '0;
      rd_sel <= 1'b0;
      rd_sym <= '0;
      play   <= 1'b0;
      tx_en  <= 1'b0;
      txd    <= '0;
    end else begin
      if (raw_valid) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      if (raw_valid && int'(wr_cnt) == eth_phy_pkg::sym_per_byte - 1) begin
        // Byte complete, its last symbol goes out straight from the input
        wr_sel <= ~wr_sel;
        rd_sel <= wr_sel;
        rd_sym <= cnt_w'(eth_phy_pkg::sym_per_byte - 2);
        play   <= 1'b1;
        tx_en  <= 1'b1;
        txd    <= flip(raw_sym);
      end else if (play) begin
        play   <= (rd_sym != '0);
        rd_sym <= rd_sym - 1'b1;
        tx_en  <= 1'b1;
        txd    <= flip(byte_buf[rd_sel][7 - eth_phy_pkg::sym_w*rd_sym -: eth_phy_pkg::sym_w]);
      end else begin
        tx_en <= 1'b0;
        txd   <= '0;
      end
    end
  end

  // Upstream sends whole bytes only
  a_byte_aligned_end : assert property (
    @(posedge clk) disable iff (!arst_n)
    $fell(raw_valid) |-> (wr_cnt == '0)
  ) else $error("eth_bit_order: raw_valid dropped inside a byte");

endmodule

// ==== verilog/eth_crc32.sv ====
`timescale 1ns/10ps

module eth_crc32 (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        crc_clear,
  input  logic        crc_en,
  input  logic [7:0]  crc_byte,
  output logic [31:0] crc_value
);

  logic [31:0] rem;        // Running remainder
  logic [31:0] rem_next;

  // Fold one byte in, LSB first, as eight reflected shift steps
  always_comb begin
    rem_next = rem ^ {24'd0, crc_byte};
    for (int i = 0; i < 8; i++) begin
      if (rem_next[0]) begin
        rem_next = (rem_next >> 1) ^ eth_frame_pkg::crc_poly_refl;
      end else begin
        rem_next = rem_next >> 1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rem <= eth_frame_pkg::crc_init;
    end else if (crc_clear) begin
      rem <= eth_frame_pkg::crc_init;
    end else if (crc_en) begin
      rem <= rem_next;
    end
  end

  assign crc_value = ~rem;   // FCS as sent

  // Framer only clears at frame start, never while bytes are folded in
  a_clear_or_en : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(crc_clear && crc_en)
  ) else $error("eth_crc32: clear and enable in the same cycle");

endmodule

// ==== verilog/eth_tx.sv ====
`timescale 1ns/10ps

module eth_tx (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [eth_frame_pkg::mac_w-1:0]   my_mac,
  input  logic [eth_frame_pkg::mac_w-1:0]   dest_mac,
  input  logic [eth_frame_pkg::etype_w-1:0] etype,
  input  logic [7:0]                        pl_data,
  input  logic                              pl_valid,
  input  logic                              pl_last,
  output logic                              pl_ready,
  output logic [eth_phy_pkg::sym_w-1:0]     txd,
  output logic                              tx_en
);

  // Framer and header generator
  logic        hdr_start;
  logic        hdr_next;
  logic [7:0]  hdr_byte;
  logic        hdr_last;
  logic        hdr_in_crc;

  // Framer and CRC
  logic        crc_clear;
  logic        crc_en;
  logic [7:0]  crc_byte;
  logic [31:0] crc_value;

  logic                          raw_valid;
  logic [eth_phy_pkg::sym_w-1:0] raw_sym;

  eth_tx_framer framer0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .pl_data    (pl_data),
    .pl_valid   (pl_valid),
    .pl_last    (pl_last),
    .pl_ready   (pl_ready),
    .hdr_start  (hdr_start),
    .hdr_next   (hdr_next),
    .hdr_byte   (hdr_byte),
    .hdr_last   (hdr_last),
    .hdr_in_crc (hdr_in_crc),
    .crc_clear  (crc_clear),
    .crc_en     (crc_en),
    .crc_byte   (crc_byte),
    .crc_value  (crc_value),
    .raw_valid  (raw_valid),
    .raw_sym    (raw_sym)
  );

  eth_header_gen hdr0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .hdr_start  (hdr_start),
    .hdr_next   (hdr_next),
    .my_mac     (my_mac),
    .dest_mac   (dest_mac),
    .etype      (etype),
    .hdr_byte   (hdr_byte),
    .hdr_last   (hdr_last),
    .hdr_in_crc (hdr_in_crc)
  );

  eth_crc32 crc0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .crc_clear (crc_clear),
    .crc_en    (crc_en),
    .crc_byte  (crc_byte),
    .crc_value (crc_value)
  );

  eth_bit_order order0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .raw_valid (raw_valid),
    .raw_sym   (raw_sym),
    .tx_en     (tx_en),
    .txd       (txd)
  );

endmodule
